// ==== sources.f ====
verilog/bufferPkg.sv
verilog/statusPkg.sv
verilog/widthConvRam.sv
verilog/sampleWriter.sv
verilog/wordReader.sv
verilog/fillTracker.sv
verilog/packBuffer.sv
bench/clockGen.sv
bench/packBuffer_sva.sv
bench/packBufferTb.sv

// ==== Makefile ====
# Verilator flow for the sample packing buffer
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= packBufferTb
FILELIST  ?= sources.f
LATENCY   ?= 3
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Set LATENCY=1 or LATENCY=3 to pick the RAM read latency"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GreadLatency=$(LATENCY) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "Simulation gave no verdict"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/packBufferTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module packBufferTb #(parameter int readLatency = 3);

    localparam int DrainTimeout = 2000;
    localparam int ResetTimeout = 100;
    localparam int RandomCycles = 3000;

    logic clkA;
    logic rstN;
    logic sampleValid;
    bufferPkg::sample_t sampleIn;
    logic wordReq;
    logic wordValid;
    bufferPkg::word_t wordOut;
    statusPkg::bufStatus_t status;

    // Reference model of stored samples and owed words
    bufferPkg::sample_t sampleQ[$];
    bufferPkg::word_t wordQ[$];
    bufferPkg::word_t expWord;
    int modelLevel;
    logic expOverflow;
    logic expUnderflow;

    int seed;
    int errorCount;
    int testCount;
    int testStartErrors;
    int wordsSeen;
    int waited;

    clockGen clk_i (.clkA(clkA), .rstN(rstN));

    packBuffer #(.readLatency(readLatency)) dut_i (
        .clkA        (clkA),
        .rstN        (rstN),
        .sampleValid (sampleValid),
        .sampleIn    (sampleIn),
        .wordReq     (wordReq),
        .wordValid   (wordValid),
        .wordOut     (wordOut),
        .status      (status)
    );

    ////////////////////////////////////////
    // Checks at the drive point
    ////////////////////////////////////////

    task automatic checkStatus();
        assert (status.level == statusPkg::level_t'(modelLevel)) else begin
            $display("FAILED status.level got %h expected %h",
                status.level, statusPkg::level_t'(modelLevel));
            errorCount++;
        end
        assert (status.full == (modelLevel == bufferPkg::RamDepth)) else begin
            $display("FAILED status.full got %h expected %h",
                status.full, (modelLevel == bufferPkg::RamDepth));
            errorCount++;
        end
        assert (status.wordAvail == (modelLevel >= 2)) else begin
            $display("FAILED status.wordAvail got %h expected %h",
                status.wordAvail, (modelLevel >= 2));
            errorCount++;
        end
        assert (status.overflow == expOverflow) else begin
            $display("FAILED status.overflow got %h expected %h", status.overflow, expOverflow);
            errorCount++;
        end
        assert (status.underflow == expUnderflow) else begin
            $display("FAILED status.underflow got %h expected %h",
                status.underflow, expUnderflow);
            errorCount++;
        end
    endtask

    // One clock of stimulus and the model update for the next edge
    task automatic stepCycle(input logic doWrite, input logic doRead);
        int randVal;
        logic acceptWrite;
        logic acceptRead;
        bufferPkg::sample_t lowSample;
        bufferPkg::sample_t highSample;
        @(posedge clkA);
        #1;
        checkStatus();
        randVal = $random(seed);
        acceptWrite = doWrite && (modelLevel < bufferPkg::RamDepth);
        acceptRead = doRead && (modelLevel >= 2);
        sampleValid = doWrite;
        sampleIn = randVal[15:0];
        wordReq = doRead;
        expOverflow = doWrite && !acceptWrite;
        expUnderflow = doRead && !acceptRead;
        // Older sample goes low
        if (acceptRead) begin
            lowSample = sampleQ.pop_front();
            highSample = sampleQ.pop_front();
            wordQ.push_back({highSample, lowSample});
            modelLevel -= 2;
        end
        if (acceptWrite) begin
            sampleQ.push_back(sampleIn);
            modelLevel++;
        end
    endtask

    // Idle until every owed word came out
    task automatic waitDrain();
        int cycles;
        cycles = 0;
        while (wordQ.size() > 0 && cycles < DrainTimeout) begin
            stepCycle(1'b0, 1'b0);
            cycles++;
        end
        if (wordQ.size() > 0) begin
            $display("timed out after %0d cycles with %0d words still owed",
                cycles, wordQ.size());
            errorCount++;
            wordQ.delete();
        end
    endtask

    task automatic finishTest(input string name);
        $display("%-10s done, %0d errors", name, errorCount - testStartErrors);
        testCount++;
        testStartErrors = errorCount;
    endtask

    // Output words checked mid cycle against the model
    always @(negedge clkA) begin
        if (rstN && wordValid) begin
            wordsSeen++;
            if (wordQ.size() == 0) begin
                $display("wordValid pulsed while no word was owed");
                errorCount++;
            end else begin
                expWord = wordQ.pop_front();
                assert (wordOut == expWord) else begin
                    $display("FAILED wordOut got %h expected %h", wordOut, expWord);
                    errorCount++;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    task automatic runTests();
        int r;
        repeat (4) stepCycle(1'b0, 1'b0);
        finishTest("reset");
        // Spaced requests
        repeat (6) stepCycle(1'b1, 1'b0);
        repeat (3) begin
            stepCycle(1'b0, 1'b1);
            repeat (readLatency + 2) stepCycle(1'b0, 1'b0);
        end
        waitDrain();
        finishTest("small");
        // Several reads in flight
        repeat (10) stepCycle(1'b1, 1'b0);
        repeat (5) stepCycle(1'b0, 1'b1);
        waitDrain();
        finishTest("pipelined");
        // Fill, one dropped strobe, then drain
        repeat (bufferPkg::RamDepth) stepCycle(1'b1, 1'b0);
        stepCycle(1'b1, 1'b0);
        repeat (2) stepCycle(1'b0, 1'b0);
        repeat (bufferPkg::RamDepth / 2) stepCycle(1'b0, 1'b1);
        waitDrain();
        finishTest("fill");
        // Request below one word
        stepCycle(1'b0, 1'b1);
        stepCycle(1'b1, 1'b0);
        stepCycle(1'b0, 1'b1);
        repeat (readLatency + 3) stepCycle(1'b0, 1'b0);
        stepCycle(1'b1, 1'b0);
        stepCycle(1'b0, 1'b1);
        waitDrain();
        finishTest("underflow");
        // Writes three in four, reads one in two
        repeat (RandomCycles) begin
            r = $random(seed);
            stepCycle(r[1:0] != 2'b00, r[2]);
        end
        waitDrain();
        finishTest("random");
    endtask

    initial begin
        sampleValid = 1'b0;
        sampleIn = '0;
        wordReq = 1'b0;
        seed = 32'hdfff9898;
        modelLevel = 0;
        expOverflow = 1'b0;
        expUnderflow = 1'b0;
        errorCount = 0;
        testCount = 0;
        testStartErrors = 0;
        wordsSeen = 0;
        waited = 0;
        // Reset may still be unknown at time zero
        while (rstN !== 1'b1 && waited < ResetTimeout) begin
            @(posedge clkA);
            waited++;
        end
        if (rstN === 1'b1) begin
            runTests();
        end else begin
            $display("reset was never released");
            errorCount++;
        end
        errorCount += dut_i.sva_i.failCount;
        $display("%0d tests, %0d words checked, %0d errors", testCount, wordsSeen, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/packBuffer_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module packBufferSva #(
    parameter int readLatency = bufferPkg::DefaultReadLatency
) (
    input logic                  clkA,
    input logic                  rstN,
    input logic                  sampleValid,
    input logic                  wordReq,
    input logic                  wordValid,
    input statusPkg::bufStatus_t status
);

    int failCount;
    statusPkg::level_t nextLevel;

    initial failCount = 0;

    // Level expected after this edge
    always_comb begin
        nextLevel = status.level;
        if (sampleValid && !status.full) begin
            nextLevel = nextLevel + statusPkg::level_t'(1);
        end
        if (wordReq && status.wordAvail) begin
            nextLevel = nextLevel - statusPkg::level_t'(2);
        end
    end

    ////////////////////////////////////////
    // Reset state
    ////////////////////////////////////////

    resetState: assert property (@(posedge clkA) $rose(rstN) |->
        (status.level == '0) && !status.full && !status.wordAvail
        && !status.overflow && !status.underflow && !wordValid)
        else begin failCount++; $error("status not clear after reset"); end

    ////////////////////////////////////////
    // Read latency
    ////////////////////////////////////////

    // Accepted request to its valid pulse
    reqToValid: assert property (@(posedge clkA) disable iff (!rstN)
        (wordReq && status.wordAvail) |-> ##(readLatency+1) wordValid)
        else begin failCount++; $error("wordValid missing after request"); end

    validHasReq: assert property (@(posedge clkA) disable iff (!rstN)
        wordValid |-> $past(wordReq && status.wordAvail, readLatency+1))
        else begin failCount++; $error("wordValid without accepted request"); end

    ////////////////////////////////////////
    // Level and flags
    ////////////////////////////////////////

    levelStep: assert property (@(posedge clkA) disable iff (!rstN)
        1'b1 |=> status.level == $past(nextLevel))
        else begin failCount++; $error("level step wrong"); end

    fullFlag: assert property (@(posedge clkA) disable iff (!rstN)
        status.full == (status.level == statusPkg::level_t'(bufferPkg::RamDepth)))
        else begin failCount++; $error("full disagrees with level"); end

    availFlag: assert property (@(posedge clkA) disable iff (!rstN)
        status.wordAvail == (status.level >= statusPkg::level_t'(2)))
        else begin failCount++; $error("wordAvail disagrees with level"); end

    // Error pulses last exactly one cycle per rejected input
    overflowPulse: assert property (@(posedge clkA) disable iff (!rstN)
        1'b1 |=> status.overflow == $past(sampleValid && status.full))
        else begin failCount++; $error("overflow pulse wrong"); end

    underflowPulse: assert property (@(posedge clkA) disable iff (!rstN)
        1'b1 |=> status.underflow == $past(wordReq && !status.wordAvail))
        else begin failCount++; $error("underflow pulse wrong"); end

endmodule

bind packBuffer packBufferSva #(.readLatency(readLatency)) sva_i (
    .clkA        (clkA),
    .rstN        (rstN),
    .sampleValid (sampleValid),
    .wordReq     (wordReq),
    .wordValid   (wordValid),
    .status      (status)
);

`default_nettype wire

// ==== bench/clockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clockGen (
    output logic clkA,
    output logic rstN
);

    localparam int HalfPeriod = 4;
    localparam int ResetCycles = 10;

    // Free running 8 ns clock
    initial begin
        clkA = 1'b0;
        forever #(HalfPeriod) clkA = ~clkA;
    end

    // Reset low for ten edges, released just after an edge
    initial begin
        rstN = 1'b0;
        repeat (ResetCycles) @(posedge clkA);
        #1;
        rstN = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verilog/packBuffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module packBuffer #(
    parameter int readLatency = bufferPkg::DefaultReadLatency
) (
    input  logic                  clkA,
    input  logic                  rstN,
    input  logic                  sampleValid,
    input  bufferPkg::sample_t    sampleIn,
    input  logic                  wordReq,
    output logic                  wordValid,
    output bufferPkg::word_t      wordOut,
    output statusPkg::bufStatus_t status
);

    // RAM ports
    bufferPkg::ramWrite_t wrPort;
    bufferPkg::ramRead_t rdPort;
    bufferPkg::word_t rdData;

    // Accept pulses into the tracker
    logic wrAccepted;
    logic rdAccepted;

    ////////////////////////////////////////
    // Producer side
    ////////////////////////////////////////

    sampleWriter writer_i (
        .clkA        (clkA),
        .rstN        (rstN),
        .sampleValid (sampleValid),
        .sampleIn    (sampleIn),
        .full        (status.full),
        .wrPort      (wrPort),
        .wrAccepted  (wrAccepted)
    );

    ////////////////////////////////////////
    // Consumer side
    ////////////////////////////////////////

    wordReader #(.readLatency(readLatency)) reader_i (
        .clkA       (clkA),
        .rstN       (rstN),
        .wordReq    (wordReq),
        .wordAvail  (status.wordAvail),
        .rdData     (rdData),
        .rdPort     (rdPort),
        .rdAccepted (rdAccepted),
        .wordValid  (wordValid),
        .wordOut    (wordOut)
    );

    // Level and error flags
    fillTracker tracker_i (
        .clkA        (clkA),
        .rstN        (rstN),
        .wrAccepted  (wrAccepted),
        .rdAccepted  (rdAccepted),
        .sampleValid (sampleValid),
        .wordReq     (wordReq),
        .status      (status)
    );

    widthConvRam #(.readLatency(readLatency)) ram_i (
        .clkA   (clkA),
        .wrPort (wrPort),
        .rdPort (rdPort),
        .rdData (rdData)
    );

endmodule

`default_nettype wire

// ==== verilog/fillTracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module fillTracker (
    input  logic                   clkA,
    input  logic                   rstN,
    input  logic                   wrAccepted,
    input  logic                   rdAccepted,
    input  logic                   sampleValid,
    input  logic                   wordReq,
    output statusPkg::bufStatus_t  status
);

    statusPkg::level_t level;
    logic overflow;
    logic underflow;

    ////////////////////////////////////////
    // Sample count
    ////////////////////////////////////////

    // One up per write, two down per word read
    always_ff @(posedge clkA) begin
        if (!rstN) begin
            level <= '0;
        end else begin
            level <= level + statusPkg::level_t'(wrAccepted)
                - (rdAccepted ? statusPkg::level_t'(bufferPkg::SamplesPerWord) : '0);
        end
    end

    // Rejected strobes and requests
    always_ff @(posedge clkA) begin
        if (!rstN) begin
            overflow <= 1'b0;
            underflow <= 1'b0;
        end else begin
            overflow <= sampleValid && !wrAccepted;
            underflow <= wordReq && !rdAccepted;
        end
    end

    ////////////////////////////////////////
    // Status word
    ////////////////////////////////////////

    always_comb begin
        status.level = level;
        status.full = (level == statusPkg::level_t'(bufferPkg::RamDepth));
        status.wordAvail = (level >= statusPkg::level_t'(bufferPkg::SamplesPerWord));
        status.overflow = overflow;
        status.underflow = underflow;
    end

endmodule

`default_nettype wire

// ==== verilog/wordReader.sv ====
`timescale 1ns/1ps
`default_nettype none

module wordReader #(
    parameter int readLatency = bufferPkg::DefaultReadLatency
) (
    input  logic                clkA,
    input  logic                rstN,
    input  logic                wordReq,
    input  logic                wordAvail,
    input  bufferPkg::word_t    rdData,
    output bufferPkg::ramRead_t rdPort,
    output logic                rdAccepted,
    output logic                wordValid,
    output bufferPkg::word_t    wordOut
);

    // Next word to hand out
    bufferPkg::wordAddr_t rdPtr;

    // One bit per RAM output stage
    logic [readLatency-1:0] validPipe;

    ////////////////////////////////////////
    // Request acceptance
    ////////////////////////////////////////

    assign rdAccepted = wordReq && wordAvail;

    always_ff @(posedge clkA) begin
        if (!rstN) begin
            rdPtr <= '0;
            rdPort.en <= 1'b0;
        end else begin
            rdPort.en <= rdAccepted;
            if (rdAccepted) begin
                rdPtr <= rdPtr + 1'b1;
            end
        end
    end

    // Address captured with the request
    always_ff @(posedge clkA) begin
        rdPort.addr <= rdPtr;
    end

    ////////////////////////////////////////
    // Valid alignment
    ////////////////////////////////////////

    // Tracks each read through the RAM output stages
    always_ff @(posedge clkA) begin
        if (!rstN) begin
            validPipe <= '0;
        end else begin
            validPipe[0] <= rdPort.en;
            for (int i = 1; i < readLatency; i++) begin
                validPipe[i] <= validPipe[i-1];
            end
        end
    end

    assign wordValid = validPipe[readLatency-1];
    assign wordOut = rdData;

endmodule

`default_nettype wire

// ==== verilog/sampleWriter.sv ====
`timescale 1ns/1ps
`default_nettype none

module sampleWriter (
    input  logic                 clkA,
    input  logic                 rstN,
    input  logic                 sampleValid,
    input  bufferPkg::sample_t   sampleIn,
    input  logic                 full,
    output bufferPkg::ramWrite_t wrPort,
    output logic                 wrAccepted
);

    // Next free sample slot
    bufferPkg::sampleAddr_t wrPtr;

    ////////////////////////////////////////
    // Acceptance
    ////////////////////////////////////////

    // Strobes while full are lost
    assign wrAccepted = sampleValid && !full;

    // Write lands in the RAM at the same edge
    always_comb begin
        wrPort.en = wrAccepted;
        wrPort.addr = wrPtr;
        wrPort.data = sampleIn;
    end

    ////////////////////////////////////////
    // Write pointer
    ////////////////////////////////////////

    // Wraps at the end of the RAM on its own
    always_ff @(posedge clkA) begin
        if (!rstN) begin
            wrPtr <= '0;
        end else if (wrAccepted) begin
            wrPtr <= wrPtr + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/widthConvRam.sv ====
`timescale 1ns/1ps
`default_nettype none

module widthConvRam #(
    parameter int readLatency = bufferPkg::DefaultReadLatency
) (
    input  logic                 clkA,
    input  bufferPkg::ramWrite_t wrPort,
    input  bufferPkg::ramRead_t  rdPort,
    output bufferPkg::word_t     rdData
);

    // Storage in narrow units
    bufferPkg::sample_t mem [bufferPkg::RamDepth];

    // Output register chain, last entry drives rdData
    bufferPkg::word_t readPipe [readLatency];
    bufferPkg::word_t readWord;

    ////////////////////////////////////////
    // Narrow write port
    ////////////////////////////////////////

    always_ff @(posedge clkA) begin
        if (wrPort.en) begin
            mem[wrPort.addr] <= wrPort.data;
        end
    end

    ////////////////////////////////////////
    // Wide read port
    ////////////////////////////////////////

    // Gather the samples of one word, earlier sample low
    always_comb begin
        readWord = '0;
        for (int s = 0; s < bufferPkg::SamplesPerWord; s++) begin
            readWord[s*bufferPkg::SampleWidth +: bufferPkg::SampleWidth] =
                mem[bufferPkg::sampleAddr_t'(rdPort.addr * bufferPkg::SamplesPerWord + s)];
        end
    end

    // First stage loads on enable
    // Later stages shift every cycle so reads overlap
    always_ff @(posedge clkA) begin
        if (rdPort.en) begin
            readPipe[0] <= readWord;
        end
        for (int i = 1; i < readLatency; i++) begin
            readPipe[i] <= readPipe[i-1];
        end
    end

    assign rdData = readPipe[readLatency-1];

endmodule

`default_nettype wire

// ==== verilog/statusPkg.sv ====
`default_nettype none

package statusPkg;

    ////////////////////////////////////////
    // Fill level and flags
    ////////////////////////////////////////

    // One extra bit so a full buffer reads as 1024
    localparam int LevelWidth = $clog2(bufferPkg::RamDepth) + 1;

    typedef logic [LevelWidth-1:0] level_t;

    typedef struct packed {
        level_t level;
        logic full;
        logic wordAvail;
        // Single cycle error pulses
        logic overflow;
        logic underflow;
    } bufStatus_t;

endpackage

`default_nettype wire

// ==== verilog/bufferPkg.sv ====
`default_nettype none

package bufferPkg;

    ////////////////////////////////////////
    // Data path widths
    ////////////////////////////////////////

    localparam int SampleWidth = 16;
    localparam int WordWidth = 32;
    localparam int SamplesPerWord = WordWidth / SampleWidth;

    ////////////////////////////////////////
    // Memory geometry
    ////////////////////////////////////////

    // Depth counted in narrow samples
    localparam int RamDepth = 1024;
    localparam int SampleAddrWidth = $clog2(RamDepth);
    localparam int WordAddrWidth = $clog2(RamDepth / SamplesPerWord);

    // Low latency choice, 3 selects high performance
    localparam int DefaultReadLatency = 1;

    typedef logic [SampleWidth-1:0] sample_t;
    typedef logic [WordWidth-1:0] word_t;
    typedef logic [SampleAddrWidth-1:0] sampleAddr_t;
    typedef logic [WordAddrWidth-1:0] wordAddr_t;

    // Narrow write port
    typedef struct packed {
        logic en;
        sampleAddr_t addr;
        sample_t data;
    } ramWrite_t;

    // Wide read port
    typedef struct packed {
        logic en;
        wordAddr_t addr;
    } ramRead_t;

endpackage

`default_nettype wire
